/* Makefile */
# Verilator build, run and lint for the decode-to-execute stage

TOP := tb_decode_execute

all: run

obj_dir/sim_decode_execute: decode_execute.f *.sv
	verilator --binary --timing --assert --top-module $(TOP) -f decode_execute.f -o sim_decode_execute

run: obj_dir/sim_decode_execute
	@out="$$(./obj_dir/sim_decode_execute)"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f decode_execute.f

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

/* branch_unit.sv */
// ----------------------------------------------------------
// Branch resolution in the decode stage.
// Produces the taken flag and target for fetch in the same
// cycle, and registers the prediction, the mispredict
// target, the link result and the misaligned-target
// exception for the execute stage on each advance.
// ----------------------------------------------------------

module branch_unit (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   padv_i,
   input  logic                   pipeline_flush_i,
   input  de_insn_pkg::op_class_e decode_op_i,
   input  de_cfg_pkg::operand_t   pc_decode_i,
   input  de_cfg_pkg::imm_t       decode_imm_i,
   input  logic                   predicted_flag_i,
   input  de_cfg_pkg::operand_t   decode_rfb_i,
   input  de_cfg_pkg::operand_t   execute_rfb_i,
   input  logic                   jr_hazard_i,
   ex_state_if.peer               ex,
   output logic                   decode_branch_o,
   output de_cfg_pkg::operand_t   decode_branch_target_o,
   output logic                   execute_predicted_flag_o,
   output de_cfg_pkg::operand_t   execute_mispredict_target_o,
   output de_cfg_pkg::operand_t   execute_jal_result_o,
   output logic                   execute_except_ibus_align_o
);

   localparam int sext_bits = de_cfg_pkg::operand_width - de_cfg_pkg::imm_width - 2;

   logic                 branch_to_imm;
   logic                 branch_to_reg;
   logic                 predict_wrong_way;
   logic                 decode_except_align;
   de_cfg_pkg::operand_t imm_offset;
   de_cfg_pkg::operand_t imm_target;
   de_cfg_pkg::operand_t reg_target;
   de_cfg_pkg::operand_t next_pc;
   de_cfg_pkg::operand_t mispredict_target;

   // word offset sign extended to the pc width
   assign imm_offset = {{sext_bits{decode_imm_i[de_cfg_pkg::imm_width-1]}},
                        decode_imm_i, 2'b00};
   assign imm_target = pc_decode_i + imm_offset;

   // l.j/l.jal always, bf/bnf when the predicted flag agrees
   assign branch_to_imm = de_insn_pkg::imm_jump(decode_op_i) ||
                          (decode_op_i == de_insn_pkg::op_branch_f && predicted_flag_i) ||
                          (decode_op_i == de_insn_pkg::op_branch_nf && !predicted_flag_i);

   assign branch_to_reg = (decode_op_i == de_insn_pkg::op_jump_reg) && !jr_hazard_i;

   // after a bubble the producing result sits in the execute operand
   assign reg_target = (ex.ex_bubble || ex.ex_op == de_insn_pkg::op_jump_reg) ?
                       execute_rfb_i : decode_rfb_i;

   assign decode_branch_o = (branch_to_imm || branch_to_reg) && !pipeline_flush_i;
   assign decode_branch_target_o = branch_to_imm ? imm_target : reg_target;

   // taken target must be word aligned
   assign decode_except_align = decode_branch_o && (|decode_branch_target_o[1:0]);

   // return point always skips the delay slot
   assign next_pc = pc_decode_i + de_cfg_pkg::pc_step_delay_slot;

   // fetch went the wrong way if the prediction disagrees with the branch sense
   assign predict_wrong_way = (decode_op_i == de_insn_pkg::op_branch_f && !predicted_flag_i) ||
                              (decode_op_i == de_insn_pkg::op_branch_nf && predicted_flag_i);
   assign mispredict_target = predict_wrong_way ? imm_target : next_pc;

   // prediction state is only meaningful for conditional branches
   always_ff @(posedge clk) begin
      if (padv_i && de_insn_pkg::cond_branch(decode_op_i)) begin
         execute_mispredict_target_o <= mispredict_target;
         execute_predicted_flag_o    <= predicted_flag_i;
      end
   end

   always_ff @(posedge clk) begin
      if (padv_i) begin
         execute_jal_result_o <= next_pc;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         execute_except_ibus_align_o <= 1'b0;
      end else if (padv_i) begin
         execute_except_ibus_align_o <= decode_except_align;
      end
   end

   // fetch is only redirected once a pending jump target has arrived
   a_no_branch_on_jr_hazard: assert property (
      @(posedge clk) disable iff (rst) jr_hazard_i |-> !decode_branch_o
   ) else $error("decode branch taken while the register jump target is pending");

endmodule

/* de_cfg_pkg.sv */
// ----------------------------------------------------------
// Configuration constants for the decode-to-execute stage.
// Holds the data, register-number and immediate widths,
// the delay-slot pc step and the execute pc after reset.
// Files refer to these by scoped names.
// ----------------------------------------------------------

package de_cfg_pkg;

   // data path and pc width
   localparam int operand_width = 32;

   // register file address width, 32 registers
   localparam int rf_adr_width = 5;

   // jump/branch immediate as carried by the 26-bit format
   localparam int imm_width = 26;

   // a branch returns past its delay slot
   localparam int pc_step_delay_slot = 8;

   // execute pc right after reset
   localparam logic [operand_width-1:0] reset_pc = 32'h0000_0100;

   // vector types of the widths above
   typedef logic [operand_width-1:0] operand_t;
   typedef logic [rf_adr_width-1:0]  rf_adr_t;
   typedef logic [imm_width-1:0]     imm_t;

endpackage

/* de_insn_pkg.sv */
// ----------------------------------------------------------
// Instruction classes seen by the decode-to-execute stage.
// One enum replaces the per-operation flags, and a few
// helper functions group the classes the way the hazard
// and branch logic needs them.
// ----------------------------------------------------------

package de_insn_pkg;

   typedef enum logic [3:0] {
      op_nop       = 4'd0,
      op_alu       = 4'd1,
      op_load      = 4'd2,
      op_store     = 4'd3,
      op_mfspr     = 4'd4,
      op_mtspr     = 4'd5,
      op_jump      = 4'd6,
      op_jump_link = 4'd7,
      op_jump_reg  = 4'd8,
      op_branch_f  = 4'd9,
      op_branch_nf = 4'd10,
      op_rfe       = 4'd11
   } op_class_e;

   // result only becomes available in the control stage
   function automatic logic late_result(op_class_e op);
      return (op == op_load) || (op == op_mfspr);
   endfunction

   // flag-dependent branches
   function automatic logic cond_branch(op_class_e op);
      return (op == op_branch_f) || (op == op_branch_nf);
   endfunction

   // unconditional jumps to an immediate target
   function automatic logic imm_jump(op_class_e op);
      return (op == op_jump) || (op == op_jump_link);
   endfunction

endpackage

/* decode_execute.f */
de_cfg_pkg.sv
de_insn_pkg.sv
ex_state_if.sv
hazard_unit.sv
branch_unit.sv
stage_regs.sv
decode_execute.sv
tb_decode_execute.sv

/* decode_execute.sv */
// ----------------------------------------------------------
// Decode-to-execute boundary of the in-order pipeline.
// Ties the stage registers, the hazard unit and the branch
// unit together through the shared execute state. Advanced
// by padv_i, squashed by pipeline_flush_i.
// ----------------------------------------------------------

module decode_execute (
   input  logic                   clk,
   input  logic                   rst,

   // pipeline control
   input  logic                   padv_i,
   input  logic                   pipeline_flush_i,

   // decoded instruction
   input  de_insn_pkg::op_class_e decode_op_i,
   input  de_cfg_pkg::rf_adr_t    decode_rfd_adr_i,
   input  de_cfg_pkg::rf_adr_t    decode_rfa_adr_i,
   input  de_cfg_pkg::rf_adr_t    decode_rfb_adr_i,
   input  logic                   decode_rf_wb_i,
   input  de_cfg_pkg::imm_t       decode_imm_i,
   input  de_cfg_pkg::operand_t   pc_decode_i,

   // register file operands and prediction
   input  de_cfg_pkg::operand_t   decode_rfb_i,
   input  de_cfg_pkg::operand_t   execute_rfb_i,
   input  logic                   predicted_flag_i,

   // control stage state
   input  de_insn_pkg::op_class_e ctrl_op_i,
   input  de_cfg_pkg::rf_adr_t    ctrl_rfd_adr_i,

   // execute stage
   output de_insn_pkg::op_class_e execute_op_o,
   output logic                   execute_rf_wb_o,
   output de_cfg_pkg::rf_adr_t    execute_rfd_adr_o,
   output de_cfg_pkg::imm_t       execute_imm_o,
   output de_cfg_pkg::operand_t   pc_execute_o,
   output logic                   execute_bubble_o,
   output logic                   execute_predicted_flag_o,
   output de_cfg_pkg::operand_t   execute_mispredict_target_o,
   output de_cfg_pkg::operand_t   execute_jal_result_o,
   output logic                   execute_except_ibus_align_o,

   // decode stage status
   output logic                   decode_valid_o,
   output logic                   decode_bubble_o,
   output logic                   decode_branch_o,
   output de_cfg_pkg::operand_t   decode_branch_target_o
);

   logic jr_hazard;

   ex_state_if ex_state ();

   stage_regs i_stage_regs (
      .clk               (clk),
      .rst               (rst),
      .padv_i            (padv_i),
      .pipeline_flush_i  (pipeline_flush_i),
      .decode_bubble_i   (decode_bubble_o),
      .decode_op_i       (decode_op_i),
      .decode_rfd_adr_i  (decode_rfd_adr_i),
      .decode_rf_wb_i    (decode_rf_wb_i),
      .decode_imm_i      (decode_imm_i),
      .pc_decode_i       (pc_decode_i),
      .execute_op_o      (execute_op_o),
      .execute_rf_wb_o   (execute_rf_wb_o),
      .execute_rfd_adr_o (execute_rfd_adr_o),
      .execute_imm_o     (execute_imm_o),
      .pc_execute_o      (pc_execute_o),
      .execute_bubble_o  (execute_bubble_o),
      .decode_valid_o    (decode_valid_o),
      .ex                (ex_state)
   );

   hazard_unit i_hazard_unit (
      .clk              (clk),
      .padv_i           (padv_i),
      .decode_op_i      (decode_op_i),
      .decode_rfa_adr_i (decode_rfa_adr_i),
      .decode_rfb_adr_i (decode_rfb_adr_i),
      .ctrl_op_i        (ctrl_op_i),
      .ctrl_rfd_adr_i   (ctrl_rfd_adr_i),
      .ex               (ex_state),
      .decode_bubble_o  (decode_bubble_o),
      .jr_hazard_o      (jr_hazard)
   );

   branch_unit i_branch_unit (
      .clk                         (clk),
      .rst                         (rst),
      .padv_i                      (padv_i),
      .pipeline_flush_i            (pipeline_flush_i),
      .decode_op_i                 (decode_op_i),
      .pc_decode_i                 (pc_decode_i),
      .decode_imm_i                (decode_imm_i),
      .predicted_flag_i            (predicted_flag_i),
      .decode_rfb_i                (decode_rfb_i),
      .execute_rfb_i               (execute_rfb_i),
      .jr_hazard_i                 (jr_hazard),
      .ex                          (ex_state),
      .decode_branch_o             (decode_branch_o),
      .decode_branch_target_o      (decode_branch_target_o),
      .execute_predicted_flag_o    (execute_predicted_flag_o),
      .execute_mispredict_target_o (execute_mispredict_target_o),
      .execute_jal_result_o        (execute_jal_result_o),
      .execute_except_ibus_align_o (execute_except_ibus_align_o)
   );

endmodule

/* ex_state_if.sv */
// ----------------------------------------------------------
// Execute-stage instruction state shared inside the stage.
// The stage registers drive it through the owner modport,
// the hazard and branch units read it through peer.
// Values are valid every cycle, there is no handshake.
// ----------------------------------------------------------

interface ex_state_if;

   // operation now in execute
   de_insn_pkg::op_class_e ex_op;

   // destination register and its write-back enable
   de_cfg_pkg::rf_adr_t ex_rfd_adr;
   logic ex_rf_wb;

   // execute holds a bubble pushed by the previous decode
   logic ex_bubble;

   modport owner (
      output ex_op,
      output ex_rfd_adr,
      output ex_rf_wb,
      output ex_bubble
   );

   modport peer (
      input ex_op,
      input ex_rfd_adr,
      input ex_rf_wb,
      input ex_bubble
   );

endinterface

/* hazard_unit.sv */
// ----------------------------------------------------------
// Hazard detection between decode, execute and control.
// Raises a bubble for load/mfspr-use in execute, for a
// register jump waiting on its target register, and while
// an rfe drains. Purely combinational apart from checking.
// ----------------------------------------------------------

module hazard_unit (
   input  logic                   clk,
   input  logic                   padv_i,
   input  de_insn_pkg::op_class_e decode_op_i,
   input  de_cfg_pkg::rf_adr_t    decode_rfa_adr_i,
   input  de_cfg_pkg::rf_adr_t    decode_rfb_adr_i,
   input  de_insn_pkg::op_class_e ctrl_op_i,
   input  de_cfg_pkg::rf_adr_t    ctrl_rfd_adr_i,
   ex_state_if.peer               ex,
   output logic                   decode_bubble_o,
   output logic                   jr_hazard_o
);

   logic ctrl_interlock;
   logic ex_late_use;
   logic ex_writes_rfb;
   logic decode_jr;
   logic decode_rfe;

   // control stage still producing a load/mfspr result decode reads
   assign ctrl_interlock = de_insn_pkg::late_result(ctrl_op_i) &&
                           ((decode_rfa_adr_i == ctrl_rfd_adr_i) ||
                            (decode_rfb_adr_i == ctrl_rfd_adr_i));

   // execute holds a load/mfspr whose result decode needs
   assign ex_late_use = de_insn_pkg::late_result(ex.ex_op) &&
                        ((decode_rfa_adr_i == ex.ex_rfd_adr) ||
                         (decode_rfb_adr_i == ex.ex_rfd_adr));

   // jump target register is being written by execute
   assign ex_writes_rfb = ex.ex_rf_wb && (decode_rfb_adr_i == ex.ex_rfd_adr);

   assign decode_jr  = (decode_op_i == de_insn_pkg::op_jump_reg);
   assign decode_rfe = (decode_op_i == de_insn_pkg::op_rfe);

   // register jump cannot resolve yet as its target is not in the rf
   assign jr_hazard_o = decode_jr && (ctrl_interlock || ex_writes_rfb);

   // rfe also stalls fetch while it travels up to control
   assign decode_bubble_o = (ex_late_use || jr_hazard_o || decode_rfe) && padv_i;

   // the bubble puts a nop into execute so a load-use hazard never repeats
   a_late_use_once: assert property (
      @(posedge clk) (ex_late_use && padv_i) |=> !ex_late_use
   ) else $error("load-use hazard still present after its bubble");

endmodule

/* stage_regs.sv */
// ----------------------------------------------------------
// Decode-to-execute pipeline registers.
// Loads the decoded instruction on each advance, squashes
// it to a nop on a bubble or flush, and publishes the
// execute state to the hazard and branch logic.
// An rfe is kept through its own bubble.
// ----------------------------------------------------------

module stage_regs (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   padv_i,
   input  logic                   pipeline_flush_i,
   input  logic                   decode_bubble_i,
   input  de_insn_pkg::op_class_e decode_op_i,
   input  de_cfg_pkg::rf_adr_t    decode_rfd_adr_i,
   input  logic                   decode_rf_wb_i,
   input  de_cfg_pkg::imm_t       decode_imm_i,
   input  de_cfg_pkg::operand_t   pc_decode_i,
   output de_insn_pkg::op_class_e execute_op_o,
   output logic                   execute_rf_wb_o,
   output de_cfg_pkg::rf_adr_t    execute_rfd_adr_o,
   output de_cfg_pkg::imm_t       execute_imm_o,
   output de_cfg_pkg::operand_t   pc_execute_o,
   output logic                   execute_bubble_o,
   output logic                   decode_valid_o,
   ex_state_if.owner              ex
);

   de_insn_pkg::op_class_e bubble_op;

   // the rfe has to reach control to cause its jump, so the
   // bubbles behind it carry rfe too until the flush clears them
   assign bubble_op = (decode_op_i == de_insn_pkg::op_rfe) ?
                      de_insn_pkg::op_rfe : de_insn_pkg::op_nop;

   always_ff @(posedge clk) begin
      if (rst) begin
         execute_op_o     <= de_insn_pkg::op_nop;
         execute_rf_wb_o  <= 1'b0;
         execute_bubble_o <= 1'b0;
      end else if (pipeline_flush_i) begin
         execute_op_o     <= de_insn_pkg::op_nop;
         execute_rf_wb_o  <= 1'b0;
         execute_bubble_o <= 1'b0;
      end else if (padv_i) begin
         execute_op_o     <= decode_bubble_i ? bubble_op : decode_op_i;
         execute_rf_wb_o  <= decode_rf_wb_i && !decode_bubble_i;
         execute_bubble_o <= decode_bubble_i;
      end
   end

   // operand fields, only looked at together with a valid op
   always_ff @(posedge clk) begin
      if (padv_i) begin
         execute_rfd_adr_o <= decode_rfd_adr_i;
         execute_imm_o     <= decode_imm_i;
      end
   end

   // pc follows every advance, flushed or not
   always_ff @(posedge clk) begin
      if (rst) begin
         pc_execute_o <= de_cfg_pkg::reset_pc;
      end else if (padv_i) begin
         pc_execute_o <= pc_decode_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         decode_valid_o <= 1'b0;
      end else begin
         decode_valid_o <= padv_i;
      end
   end

   // execute state for the hazard and branch units
   assign ex.ex_op      = execute_op_o;
   assign ex.ex_rfd_adr = execute_rfd_adr_o;
   assign ex.ex_rf_wb   = execute_rf_wb_o;
   assign ex.ex_bubble  = execute_bubble_o;

   // a flushed instruction must not write back
   a_flush_kills_wb: assert property (
      @(posedge clk) disable iff (rst) pipeline_flush_i |=> !execute_rf_wb_o
   ) else $error("write-back enable survived a pipeline flush");

endmodule

/* tb_decode_execute.sv */
// ----------------------------------------------------------
// Directed testbench for the decode-to-execute stage.
// Drives decoded instructions 5 units after each rising
// edge and checks the execute registers and the decode
// outputs against values worked out from the stage rules.
// ----------------------------------------------------------

module tb_decode_execute;

   // the directed tests need well under a tenth of this
   localparam int max_cycles = 2000;

   logic clk;
   logic rst;
   logic padv_i;
   logic pipeline_flush_i;
   de_insn_pkg::op_class_e decode_op_i;
   de_cfg_pkg::rf_adr_t    decode_rfd_adr_i;
   de_cfg_pkg::rf_adr_t    decode_rfa_adr_i;
   de_cfg_pkg::rf_adr_t    decode_rfb_adr_i;
   logic                   decode_rf_wb_i;
   de_cfg_pkg::imm_t       decode_imm_i;
   de_cfg_pkg::operand_t   pc_decode_i;
   de_cfg_pkg::operand_t   decode_rfb_i;
   de_cfg_pkg::operand_t   execute_rfb_i;
   logic                   predicted_flag_i;
   de_insn_pkg::op_class_e ctrl_op_i;
   de_cfg_pkg::rf_adr_t    ctrl_rfd_adr_i;
   de_insn_pkg::op_class_e execute_op_o;
   logic                   execute_rf_wb_o;
   de_cfg_pkg::rf_adr_t    execute_rfd_adr_o;
   de_cfg_pkg::imm_t       execute_imm_o;
   de_cfg_pkg::operand_t   pc_execute_o;
   logic                   execute_bubble_o;
   logic                   execute_predicted_flag_o;
   de_cfg_pkg::operand_t   execute_mispredict_target_o;
   de_cfg_pkg::operand_t   execute_jal_result_o;
   logic                   execute_except_ibus_align_o;
   logic                   decode_valid_o;
   logic                   decode_bubble_o;
   logic                   decode_branch_o;
   de_cfg_pkg::operand_t   decode_branch_target_o;

   int error_count = 0;
   int check_count = 0;
   int cycle_count = 0;

   decode_execute i_decode_execute (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= max_cycles) begin
         $display("timeout: the tests did not finish within %0d cycles", max_cycles);
         $display("TESTS FAILED");
         $finish;
      end
   end

   task automatic expect_bit(input string name, input logic expected, input logic actual);
      check_count++;
      if (actual !== expected) begin
         $display("Mismatch at %0t: %s expected %b, got %b", $time, name, expected, actual);
         error_count++;
      end
   endtask

   task automatic compare_word(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
      check_count++;
      if (actual !== expected) begin
         $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
         error_count++;
      end
   endtask

   task automatic match_op(input string name, input de_insn_pkg::op_class_e expected,
                           input de_insn_pkg::op_class_e actual);
      check_count++;
      if (actual !== expected) begin
         $display("Mismatch at %0t: %s expected %s, got %s", $time, name,
                  expected.name(), actual.name());
         error_count++;
      end
   endtask

   // word offset applied to a pc
   function automatic de_cfg_pkg::operand_t branch_dest(de_cfg_pkg::operand_t pc, int words);
      return pc + 32'(words * 4);
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #5;
   endtask

   task automatic idle_inputs();
      padv_i = 1'b0;
      pipeline_flush_i = 1'b0;
      decode_op_i = de_insn_pkg::op_nop;
      decode_rfd_adr_i = 5'd0;
      decode_rfa_adr_i = 5'd0;
      decode_rfb_adr_i = 5'd0;
      decode_rf_wb_i = 1'b0;
      decode_imm_i = 26'd0;
      pc_decode_i = 32'h0;
      decode_rfb_i = 32'h0;
      execute_rfb_i = 32'h0;
      predicted_flag_i = 1'b0;
      ctrl_op_i = de_insn_pkg::op_nop;
      ctrl_rfd_adr_i = 5'd0;
   endtask

   // decode issues on an advance
   task automatic put_decode(input de_insn_pkg::op_class_e op, input de_cfg_pkg::rf_adr_t rfd,
                             input de_cfg_pkg::rf_adr_t rfa, input de_cfg_pkg::rf_adr_t rfb,
                             input logic wb);
      padv_i = 1'b1;
      decode_op_i = op;
      decode_rfd_adr_i = rfd;
      decode_rfa_adr_i = rfa;
      decode_rfb_adr_i = rfb;
      decode_rf_wb_i = wb;
   endtask

   task automatic reset_and_pass_through();
      match_op("execute_op_o", de_insn_pkg::op_nop, execute_op_o);
      expect_bit("decode_valid_o", 1'b0, decode_valid_o);
      expect_bit("execute_rf_wb_o", 1'b0, execute_rf_wb_o);
      expect_bit("execute_bubble_o", 1'b0, execute_bubble_o);
      expect_bit("execute_except_ibus_align_o", 1'b0, execute_except_ibus_align_o);
      compare_word("pc_execute_o", de_cfg_pkg::reset_pc, pc_execute_o);
      put_decode(de_insn_pkg::op_alu, 5'd7, 5'd1, 5'd2, 1'b1);
      decode_imm_i = 26'h123;
      pc_decode_i = 32'h200;
      next_cycle();
      match_op("execute_op_o", de_insn_pkg::op_alu, execute_op_o);
      expect_bit("execute_rf_wb_o", 1'b1, execute_rf_wb_o);
      compare_word("execute_rfd_adr_o", 32'd7, 32'(execute_rfd_adr_o));
      compare_word("execute_imm_o", 32'h123, 32'(execute_imm_o));
      compare_word("pc_execute_o", 32'h200, pc_execute_o);
      expect_bit("decode_valid_o", 1'b1, decode_valid_o);
      // stalled, so execute keeps the alu op
      padv_i = 1'b0;
      decode_op_i = de_insn_pkg::op_store;
      pc_decode_i = 32'h300;
      next_cycle();
      match_op("execute_op_o", de_insn_pkg::op_alu, execute_op_o);
      compare_word("pc_execute_o", 32'h200, pc_execute_o);
      expect_bit("decode_valid_o", 1'b0, decode_valid_o);
      idle_inputs();
   endtask

   task automatic load_use_bubble();
      put_decode(de_insn_pkg::op_load, 5'd3, 5'd0, 5'd0, 1'b1);
      next_cycle();
      put_decode(de_insn_pkg::op_alu, 5'd5, 5'd3, 5'd4, 1'b1);
      #1;
      expect_bit("decode_bubble_o", 1'b1, decode_bubble_o);
      next_cycle();
      match_op("execute_op_o", de_insn_pkg::op_nop, execute_op_o);
      expect_bit("execute_rf_wb_o", 1'b0, execute_rf_wb_o);
      expect_bit("execute_bubble_o", 1'b1, execute_bubble_o);
      put_decode(de_insn_pkg::op_load, 5'd3, 5'd0, 5'd0, 1'b1);
      next_cycle();
      put_decode(de_insn_pkg::op_alu, 5'd5, 5'd1, 5'd2, 1'b0);
      #1;
      expect_bit("decode_bubble_o", 1'b0, decode_bubble_o);
      next_cycle();
      // load in control only holds up a register jump
      ctrl_op_i = de_insn_pkg::op_load;
      ctrl_rfd_adr_i = 5'd9;
      put_decode(de_insn_pkg::op_alu, 5'd5, 5'd9, 5'd2, 1'b0);
      #1;
      expect_bit("decode_bubble_o", 1'b0, decode_bubble_o);
      next_cycle();
      put_decode(de_insn_pkg::op_jump_reg, 5'd0, 5'd0, 5'd9, 1'b0);
      #1;
      expect_bit("decode_bubble_o", 1'b1, decode_bubble_o);
      expect_bit("decode_branch_o", 1'b0, decode_branch_o);
      next_cycle();
      idle_inputs();
   endtask

   task automatic register_jump();
      put_decode(de_insn_pkg::op_alu, 5'd6, 5'd0, 5'd0, 1'b1);
      next_cycle();
      put_decode(de_insn_pkg::op_jump_reg, 5'd0, 5'd0, 5'd6, 1'b0);
      pc_decode_i = 32'h600;
      decode_rfb_i = 32'h4000;
      execute_rfb_i = 32'h5000;
      #1;
      expect_bit("decode_bubble_o", 1'b1, decode_bubble_o);
      expect_bit("decode_branch_o", 1'b0, decode_branch_o);
      next_cycle();
      expect_bit("execute_bubble_o", 1'b1, execute_bubble_o);
      #1;
      expect_bit("decode_bubble_o", 1'b0, decode_bubble_o);
      expect_bit("decode_branch_o", 1'b1, decode_branch_o);
      compare_word("decode_branch_target_o", 32'h5000, decode_branch_target_o);
      next_cycle();
      // no producer in execute, target comes from the decode operand
      put_decode(de_insn_pkg::op_alu, 5'd6, 5'd0, 5'd0, 1'b0);
      next_cycle();
      put_decode(de_insn_pkg::op_jump_reg, 5'd0, 5'd0, 5'd6, 1'b0);
      #1;
      expect_bit("decode_bubble_o", 1'b0, decode_bubble_o);
      expect_bit("decode_branch_o", 1'b1, decode_branch_o);
      compare_word("decode_branch_target_o", 32'h4000, decode_branch_target_o);
      next_cycle();
      match_op("execute_op_o", de_insn_pkg::op_jump_reg, execute_op_o);
      compare_word("execute_jal_result_o", 32'h608, execute_jal_result_o);
      expect_bit("execute_except_ibus_align_o", 1'b0, execute_except_ibus_align_o);
      idle_inputs();
   endtask

   task automatic immediate_branches();
      logic                 taken;
      de_cfg_pkg::operand_t target;
      target = branch_dest(32'h1000, 16);
      for (int i = 0; i < 4; i++) begin
         put_decode((i < 2) ? de_insn_pkg::op_branch_f : de_insn_pkg::op_branch_nf,
                    5'd0, 5'd0, 5'd0, 1'b0);
         predicted_flag_i = i[0];
         pc_decode_i = 32'h1000;
         decode_imm_i = 26'd16;
         taken = (i < 2) ? predicted_flag_i : !predicted_flag_i;
         #1;
         expect_bit("decode_branch_o", taken, decode_branch_o);
         if (taken) begin
            compare_word("decode_branch_target_o", target, decode_branch_target_o);
         end
         next_cycle();
         expect_bit("execute_predicted_flag_o", predicted_flag_i, execute_predicted_flag_o);
         // a not-taken prediction must recover to the branch target
         compare_word("execute_mispredict_target_o", taken ? 32'h1008 : target,
                      execute_mispredict_target_o);
         compare_word("execute_jal_result_o", 32'h1008, execute_jal_result_o);
      end
      // backward jump, checks the sign extension
      put_decode(de_insn_pkg::op_jump_link, 5'd9, 5'd0, 5'd0, 1'b1);
      decode_imm_i = 26'(-4);
      #1;
      expect_bit("decode_branch_o", 1'b1, decode_branch_o);
      compare_word("decode_branch_target_o", branch_dest(32'h1000, -4), decode_branch_target_o);
      next_cycle();
      compare_word("execute_jal_result_o", 32'h1008, execute_jal_result_o);
      compare_word("execute_mispredict_target_o", target, execute_mispredict_target_o);
      idle_inputs();
   endtask

   task automatic flush_and_rfe();
      put_decode(de_insn_pkg::op_jump_link, 5'd9, 5'd0, 5'd0, 1'b1);
      pc_decode_i = 32'h2000;
      decode_imm_i = 26'd4;
      pipeline_flush_i = 1'b1;
      #1;
      expect_bit("decode_branch_o", 1'b0, decode_branch_o);
      next_cycle();
      match_op("execute_op_o", de_insn_pkg::op_nop, execute_op_o);
      expect_bit("execute_rf_wb_o", 1'b0, execute_rf_wb_o);
      expect_bit("execute_bubble_o", 1'b0, execute_bubble_o);
      pipeline_flush_i = 1'b0;
      put_decode(de_insn_pkg::op_rfe, 5'd0, 5'd0, 5'd0, 1'b0);
      #1;
      expect_bit("decode_bubble_o", 1'b1, decode_bubble_o);
      next_cycle();
      match_op("execute_op_o", de_insn_pkg::op_rfe, execute_op_o);
      expect_bit("execute_bubble_o", 1'b1, execute_bubble_o);
      idle_inputs();
   endtask

   task automatic misaligned_target();
      put_decode(de_insn_pkg::op_nop, 5'd0, 5'd0, 5'd0, 1'b0);
      next_cycle();
      put_decode(de_insn_pkg::op_jump_reg, 5'd0, 5'd0, 5'd1, 1'b0);
      decode_rfb_i = 32'h3002;
      execute_rfb_i = 32'h7000;
      #1;
      expect_bit("decode_branch_o", 1'b1, decode_branch_o);
      compare_word("decode_branch_target_o", 32'h3002, decode_branch_target_o);
      next_cycle();
      expect_bit("execute_except_ibus_align_o", 1'b1, execute_except_ibus_align_o);
      put_decode(de_insn_pkg::op_jump, 5'd0, 5'd0, 5'd0, 1'b0);
      pc_decode_i = 32'h3000;
      decode_imm_i = 26'd16;
      next_cycle();
      expect_bit("execute_except_ibus_align_o", 1'b0, execute_except_ibus_align_o);
      idle_inputs();
   endtask

   initial begin
      rst = 1'b1;
      idle_inputs();
      repeat (10) @(posedge clk);
      #5;
      rst = 1'b0;
      reset_and_pass_through();
      load_use_bubble();
      register_jump();
      immediate_branches();
      flush_and_rfe();
      misaligned_target();
      $display("checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule
